//--- mipsCtrlPkg.sv
package mipsCtrlPkg;

	// instruction fields
	typedef logic [5:0] opFieldT;		// opcode and funct fields
	typedef logic [2:0] aluSelT;		// alu operation code
	typedef logic [1:0] muxSel2T;		// memToReg, pcSource, aluSrcB

	// opcodes
	localparam opFieldT OpRType = 6'h00;	// funct field selects the op
	localparam opFieldT OpBeq = 6'h04;
	localparam opFieldT OpBne = 6'h05;
	localparam opFieldT OpJ = 6'h02;
	localparam opFieldT OpLui = 6'h0F;

	// funct codes, only valid with OpRType
	localparam opFieldT FunctAdd = 6'h20;
	localparam opFieldT FunctAnd = 6'h24;
	localparam opFieldT FunctSub = 6'h22;
	localparam opFieldT FunctXor = 6'h26;
	localparam opFieldT FunctBreak = 6'h0D;
	localparam opFieldT FunctNop = 6'h00;

	// alu codes
	localparam aluSelT AluPass = 3'b000;	// alu idle, passes operand a
	localparam aluSelT AluAdd = 3'b001;
	localparam aluSelT AluSub = 3'b010;
	localparam aluSelT AluAnd = 3'b011;
	localparam aluSelT AluXor = 3'b110;

	// second alu operand
	localparam muxSel2T SrcBReg = 2'b00;	// register b
	localparam muxSel2T SrcBFour = 2'b01;	// constant 4 for pc increment
	localparam muxSel2T SrcBOffset = 2'b11;	// sign extended offset shifted by 2

	// next pc source
	localparam muxSel2T PcSrcAlu = 2'b00;
	localparam muxSel2T PcSrcAluOut = 2'b01;	// branch target from decode
	localparam muxSel2T PcSrcJump = 2'b10;

	// register write data
	localparam muxSel2T MemToRegAlu = 2'b00;
	localparam muxSel2T MemToRegImm = 2'b10;	// upper immediate

	// what the decoder makes of op and funct
	typedef enum logic [3:0] {
		ClsAdd,
		ClsAnd,
		ClsSub,
		ClsXor,
		ClsBreak,
		ClsNop,
		ClsBeq,
		ClsBne,
		ClsJ,
		ClsLui,
		ClsUnknown
	} instrClassT;

	// multicycle fsm states
	typedef enum logic [4:0] {
		StReset,
		StFetch,
		StFetchWait1,
		StFetchWait2,
		StDecode,
		StAdd,
		StAnd,
		StSub,
		StXor,
		StRWrite,
		StBeq,
		StBne,
		StJ,
		StLui,
		StNop,
		StBreak
	} ctrlStateT;

endpackage

//--- instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder
	import mipsCtrlPkg::*;
(
	input opFieldT op,
	input opFieldT funct,		// only looked at for r-type
	output instrClassT instrClass
);

	instrClassT rClass;		// class from the funct field

	always_comb
	begin
		case (funct)
			FunctAdd:
				rClass = ClsAdd;
			FunctAnd:
				rClass = ClsAnd;
			FunctSub:
				rClass = ClsSub;
			FunctXor:
				rClass = ClsXor;
			FunctBreak:
				rClass = ClsBreak;
			FunctNop:
				rClass = ClsNop;
			default:
				rClass = ClsUnknown;
		endcase
	end

	// opcode first, r-type falls back to funct
	always_comb
	begin
		case (op)
			OpRType:
				instrClass = rClass;
			OpBeq:
				instrClass = ClsBeq;
			OpBne:
				instrClass = ClsBne;
			OpJ:
				instrClass = ClsJ;
			OpLui:
				instrClass = ClsLui;
			default:
				instrClass = ClsUnknown;	// lw, sw and anything else
		endcase
	end

endmodule

//--- ctrlSequencer.sv
`timescale 1ns/10ps

module ctrlSequencer
	import mipsCtrlPkg::*;
(
	input logic Clk,
	input logic reset,
	input instrClassT instrClass,
	output ctrlStateT state
);

	ctrlStateT nextState;

	// instruction class to first execute state
	function automatic ctrlStateT execState(input instrClassT cls);
		case (cls)
			ClsAdd:
				return StAdd;
			ClsAnd:
				return StAnd;
			ClsSub:
				return StSub;
			ClsXor:
				return StXor;
			ClsBreak:
				return StBreak;
			ClsNop:
				return StNop;
			ClsBeq:
				return StBeq;
			ClsBne:
				return StBne;
			ClsJ:
				return StJ;
			ClsLui:
				return StLui;
			default:
				return StFetch;		// undecoded, fetch the next one
		endcase
	endfunction

	always_comb
	begin
		case (state)
			StReset:
				nextState = StFetch;
			StFetch:
				nextState = StFetchWait1;
			StFetchWait1:
				nextState = StFetchWait2;	// memory read latency
			StFetchWait2:
				nextState = StDecode;
			StDecode:
				nextState = execState(instrClass);
			StAdd, StAnd, StSub, StXor:
				nextState = StRWrite;	// write back result
			StBreak:
				nextState = StBreak;	// halted until reset
			default:
				nextState = StFetch;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
			state <= StReset;
		else
			state <= nextState;
	end

	// halt holds across any input
	assert property (@(posedge Clk) (state == StBreak && !reset) |=> state == StBreak);

	assert property (@(posedge Clk) disable iff (reset)
		state == StDecode |=> state != StDecode);

endmodule

//--- ctrlEncoder.sv
`timescale 1ns/10ps

module ctrlEncoder
	import mipsCtrlPkg::*;
(
	input ctrlStateT state,
	input logic aluZero,		// alu result was zero
	output logic pcWrite,
	output logic pcWriteCond,
	output logic pcLoad,
	output logic irWrite,
	output logic regWrite,
	output logic datapathReset,
	output aluSelT aluSel,
	output muxSel2T memToReg,
	output muxSel2T pcSource,
	output logic aluSrcA,
	output muxSel2T aluSrcB,
	output logic iorD,
	output logic regDst,
	output logic aLoad,
	output logic bLoad,
	output logic mdrLoad,
	output logic aluOutLoad
);

	logic branchTaken;		// zero flag, inverted for bne

	always_comb
	begin
		pcWrite = 1'b0;
		pcWriteCond = 1'b0;
		irWrite = 1'b0;
		regWrite = 1'b0;
		datapathReset = 1'b0;
		aluSel = AluPass;
		memToReg = MemToRegAlu;
		pcSource = PcSrcAlu;
		aluSrcA = 1'b0;		// pc
		aluSrcB = SrcBReg;
		iorD = 1'b0;
		regDst = 1'b0;
		aLoad = 1'b0;
		bLoad = 1'b0;
		mdrLoad = 1'b0;
		aluOutLoad = 1'b0;

		case (state)
			StReset:
				datapathReset = 1'b1;	// clears all datapath registers
			StFetch, StFetchWait1:
			begin
				irWrite = 1'b1;
				mdrLoad = 1'b1;
				aluSrcB = SrcBFour;
			end
			StFetchWait2:
			begin
				irWrite = 1'b1;
				mdrLoad = 1'b1;
				aluSrcB = SrcBFour;
				aluSel = AluAdd;	// pc + 4
				pcWrite = 1'b1;
			end
			StDecode:
			begin
				// read registers and precompute the branch target
				aLoad = 1'b1;
				bLoad = 1'b1;
				aluOutLoad = 1'b1;
				aluSel = AluAdd;
				aluSrcB = SrcBOffset;
			end
			StAdd, StAnd, StSub, StXor:
			begin
				aluSrcA = 1'b1;		// register a
				aluOutLoad = 1'b1;
				case (state)
					StAdd:
						aluSel = AluAdd;
					StAnd:
						aluSel = AluAnd;
					StSub:
						aluSel = AluSub;
					default:
						aluSel = AluXor;
				endcase
			end
			StRWrite:
			begin
				regWrite = 1'b1;
				regDst = 1'b1;		// rd field
			end
			StBeq, StBne:
			begin
				pcWriteCond = 1'b1;
				aluSel = AluSub;	// compare a with b
				aluSrcA = 1'b1;
				pcSource = PcSrcAluOut;
			end
			StJ:
			begin
				pcWrite = 1'b1;
				pcSource = PcSrcJump;
				aluSel = AluAdd;
				aluSrcB = SrcBOffset;
				iorD = 1'b1;
				aluOutLoad = 1'b1;
			end
			StLui:
			begin
				regWrite = 1'b1;
				memToReg = MemToRegImm;	// rt gets the immediate
			end
			default:
			begin
			end
		endcase
	end

	assign branchTaken = (state == StBne) ? ~aluZero : aluZero;
	assign pcLoad = pcWrite | (pcWriteCond & branchTaken);

	// only one pc write source per state
	assert property (@(state) !(pcWrite && pcWriteCond));

endmodule

//--- mipsControl.sv
`timescale 1ns/10ps

module mipsControl
	import mipsCtrlPkg::*;
(
	input logic Clk,
	input logic reset,
	input opFieldT op,
	input opFieldT funct,
	input logic aluZero,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic pcLoad,
	output logic irWrite,
	output logic regWrite,
	output logic datapathReset,
	output aluSelT aluSel,
	output muxSel2T memToReg,
	output muxSel2T pcSource,
	output logic aluSrcA,
	output muxSel2T aluSrcB,
	output logic iorD,
	output logic regDst,
	output logic aLoad,
	output logic bLoad,
	output logic mdrLoad,
	output logic aluOutLoad,
	output ctrlStateT stateOut
);

	instrClassT instrClass;		// decoded, sampled in decode state
	ctrlStateT state;

	instrDecoder u_instrDecoder (
		.op(op),
		.funct(funct),
		.instrClass(instrClass)
	);

	ctrlSequencer u_ctrlSequencer (
		.Clk(Clk),
		.reset(reset),
		.instrClass(instrClass),
		.state(state)
	);

	ctrlEncoder u_ctrlEncoder (
		.state(state),
		.aluZero(aluZero),
		.pcWrite(pcWrite),
		.pcWriteCond(pcWriteCond),
		.pcLoad(pcLoad),
		.irWrite(irWrite),
		.regWrite(regWrite),
		.datapathReset(datapathReset),
		.aluSel(aluSel),
		.memToReg(memToReg),
		.pcSource(pcSource),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.iorD(iorD),
		.regDst(regDst),
		.aLoad(aLoad),
		.bLoad(bLoad),
		.mdrLoad(mdrLoad),
		.aluOutLoad(aluOutLoad)
	);

	assign stateOut = state;	// for debug and the testbench

endmodule

//--- tbMipsControl.sv
`timescale 1ns/10ps

module tbMipsControl
	import mipsCtrlPkg::*;
();

	localparam int CycleLimit = 3000;	// 200 instructions of 7 cycles plus margin

	logic Clk;
	logic reset;
	opFieldT op;
	opFieldT funct;
	logic aluZero;
	logic pcWrite, pcWriteCond, pcLoad, irWrite, regWrite, datapathReset;
	logic aluSrcA, iorD, regDst, aLoad, bLoad, mdrLoad, aluOutLoad;
	aluSelT aluSel;
	muxSel2T memToReg, pcSource, aluSrcB;
	ctrlStateT stateOut;

	ctrlStateT expState;		// reference fsm state
	logic [21:0] expOut;
	logic modelValid;
	integer seed;
	int cycleCount;
	int errorCount;
	int errMark;			// error count when the current test started
	int passCount;
	int failCount;
	ctrlStateT resetSeq[5] = '{StReset, StFetch, StFetchWait1, StFetchWait2, StDecode};
	opFieldT rFuncts[4] = '{FunctAdd, FunctAnd, FunctSub, FunctXor};

	mipsControl u_mipsControl (.*);

	always #5 Clk = ~Clk;

	// first execute state picked in decode
	function automatic ctrlStateT decodeTarget(input opFieldT o, input opFieldT f);
		ctrlStateT t;
		t = StFetch;			// anything undecoded goes back to fetch
		if (o == OpRType)
		begin
			case (f)
				FunctAdd: t = StAdd;
				FunctAnd: t = StAnd;
				FunctSub: t = StSub;
				FunctXor: t = StXor;
				FunctBreak: t = StBreak;
				FunctNop: t = StNop;
				default: t = StFetch;
			endcase
		end
		else if (o == OpBeq)
			t = StBeq;
		else if (o == OpBne)
			t = StBne;
		else if (o == OpJ)
			t = StJ;
		else if (o == OpLui)
			t = StLui;
		return t;
	endfunction

	function automatic ctrlStateT successor(input ctrlStateT st, input logic rst,
		input opFieldT o, input opFieldT f);
		if (rst)
			return StReset;
		case (st)
			StReset: return StFetch;
			StFetch: return StFetchWait1;
			StFetchWait1: return StFetchWait2;
			StFetchWait2: return StDecode;
			StDecode: return decodeTarget(o, f);
			StAdd, StAnd, StSub, StXor: return StRWrite;
			StBreak: return StBreak;	// only reset leaves
			default: return StFetch;
		endcase
	endfunction

	// bit order pcWrite pcWriteCond pcLoad irWrite regWrite datapathReset aluSel
	// memToReg pcSource aluSrcA aluSrcB iorD regDst aLoad bLoad mdrLoad aluOutLoad
	function automatic logic [21:0] controlTable(input ctrlStateT st, input logic zero);
		logic [21:0] e;
		case (st)
			StReset: e = {6'b000001, AluPass, MemToRegAlu, PcSrcAlu, 1'b0, SrcBReg, 6'b0};
			StFetch, StFetchWait1:
				e = {6'b000100, AluPass, MemToRegAlu, PcSrcAlu, 1'b0, SrcBFour, 6'b000010};
			StFetchWait2:
				e = {6'b101100, AluAdd, MemToRegAlu, PcSrcAlu, 1'b0, SrcBFour, 6'b000010};
			StDecode:
				e = {6'b0, AluAdd, MemToRegAlu, PcSrcAlu, 1'b0, SrcBOffset, 6'b001101};
			StAdd: e = {6'b0, AluAdd, MemToRegAlu, PcSrcAlu, 1'b1, SrcBReg, 6'b000001};
			StAnd: e = {6'b0, AluAnd, MemToRegAlu, PcSrcAlu, 1'b1, SrcBReg, 6'b000001};
			StSub: e = {6'b0, AluSub, MemToRegAlu, PcSrcAlu, 1'b1, SrcBReg, 6'b000001};
			StXor: e = {6'b0, AluXor, MemToRegAlu, PcSrcAlu, 1'b1, SrcBReg, 6'b000001};
			StRWrite: e = {6'b000010, AluPass, MemToRegAlu, PcSrcAlu, 1'b0, SrcBReg, 6'b010000};
			StBeq:		// taken on equal operands
				e = {2'b01, zero, 3'b000, AluSub, MemToRegAlu, PcSrcAluOut, 1'b1, SrcBReg, 6'b0};
			StBne:
				e = {2'b01, ~zero, 3'b000, AluSub, MemToRegAlu, PcSrcAluOut, 1'b1, SrcBReg, 6'b0};
			StJ: e = {6'b101000, AluAdd, MemToRegAlu, PcSrcJump, 1'b0, SrcBOffset, 6'b100001};
			StLui: e = {6'b000010, AluPass, MemToRegImm, PcSrcAlu, 1'b0, SrcBReg, 6'b0};
			default: e = 22'b0;		// nop and break drive nothing
		endcase
		return e;
	endfunction

	task automatic checkField(input string name, input logic [7:0] expV, input logic [7:0] actV);
		if (actV !== expV)
		begin
			$display("Fail %s expected %h actual %h at %0t", name, expV, actV, $time);
			errorCount++;
		end
	endtask

	task automatic stepCycle();
		@(posedge Clk);
		#1;
		aluZero = $random(seed);
	endtask

	task automatic waitFetch();
		while (stateOut !== StFetch)
			stepCycle();
	endtask

	// one instruction from fetch to the next fetch, both fetch cycles counted
	task automatic runInstr(input opFieldT o, input opFieldT f, input int expCycles);
		int cycles;
		waitFetch();
		op = o;
		funct = f;
		cycles = 1;
		stepCycle();
		cycles++;
		while (stateOut !== StFetch)
		begin
			stepCycle();
			cycles++;
		end
		if (cycles != expCycles)
		begin
			$display("op %h funct %h took %0d cycles, %0d expected", o, f, cycles, expCycles);
			errorCount++;
		end
	endtask

	task automatic endTest(input string name);
		if (errorCount == errMark)
		begin
			$display("test %s passed", name);
			passCount++;
		end
		else
		begin
			$display("test %s failed with %0d errors", name, errorCount - errMark);
			failCount++;
		end
		errMark = errorCount;
	endtask

	// model follows the dut on each rising edge
	always @(posedge Clk)
	begin
		expState = successor(expState, reset, op, funct);
		modelValid = 1'b1;
		cycleCount++;
		if (cycleCount >= CycleLimit)
		begin
			$display("run timed out after %0d cycles", cycleCount);
			$display("TEST FAILED");
			$finish;
		end
	end

	always @(negedge Clk)
	begin
		if (modelValid)
		begin
			expOut = controlTable(expState, aluZero);
			checkField("stateOut", expState, stateOut);
			checkField("pcWrite", expOut[21], pcWrite);
			checkField("pcWriteCond", expOut[20], pcWriteCond);
			checkField("pcLoad", expOut[19], pcLoad);
			checkField("irWrite", expOut[18], irWrite);
			checkField("regWrite", expOut[17], regWrite);
			checkField("datapathReset", expOut[16], datapathReset);
			checkField("aluSel", expOut[15:13], aluSel);
			checkField("memToReg", expOut[12:11], memToReg);
			checkField("pcSource", expOut[10:9], pcSource);
			checkField("aluSrcA", expOut[8], aluSrcA);
			checkField("aluSrcB", expOut[7:6], aluSrcB);
			checkField("iorD", expOut[5], iorD);
			checkField("regDst", expOut[4], regDst);
			checkField("aLoad", expOut[3], aLoad);
			checkField("bLoad", expOut[2], bLoad);
			checkField("mdrLoad", expOut[1], mdrLoad);
			checkField("aluOutLoad", expOut[0], aluOutLoad);
		end
	end

	initial
	begin
		Clk = 1'b0;
		reset = 1'b1;
		op = OpRType;
		funct = FunctNop;
		aluZero = 1'b0;
		seed = 32'h439c_3122;
		modelValid = 1'b0;
		cycleCount = 0;
		errorCount = 0;
		errMark = 0;
		passCount = 0;
		failCount = 0;

		repeat (4) stepCycle();
		reset = 1'b0;
		foreach (resetSeq[i])
		begin
			checkField("stateOut", resetSeq[i], stateOut);
			stepCycle();
		end
		endTest("reset");

		for (int i = 0; i < 12; i++)
			runInstr(OpRType, rFuncts[i % 4], 7);
		endTest("r-type");

		for (int i = 0; i < 40; i++)
			runInstr(i[0] ? OpBne : OpBeq, $random(seed), 6);	// funct is don't care
		endTest("branch");

		for (int i = 0; i < 20; i++)
			runInstr(i[0] ? OpLui : OpJ, $random(seed), 6);
		endTest("jump and lui");

		for (int i = 0; i < 10; i++)
		begin
			runInstr(OpRType, FunctNop, 6);
			runInstr(i[0] ? 6'h2B : 6'h23, $random(seed), 5);	// sw, lw
			runInstr(6'h20 | $random(seed), $random(seed), 5);	// upper opcodes unused
			runInstr(OpRType, 6'h30 | $random(seed), 5);
		end
		endTest("nop and unknown");

		waitFetch();
		op = OpRType;
		funct = FunctBreak;
		repeat (4) stepCycle();
		for (int i = 0; i < 20; i++)
		begin
			checkField("stateOut", StBreak, stateOut);
			op = $random(seed);
			funct = $random(seed);
			stepCycle();
		end
		reset = 1'b1;
		stepCycle();
		checkField("stateOut", StReset, stateOut);
		reset = 1'b0;
		repeat (2) stepCycle();
		endTest("break");

		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- vlog.f
mipsCtrlPkg.sv
instrDecoder.sv
ctrlSequencer.sv
ctrlEncoder.sv
mipsControl.sv
tbMipsControl.sv
